// File: list.f
+incdir+design
design/bank_table_pkg.sv
design/ram_initializer.sv
design/table_bank.sv
design/bank_router.sv
design/read_merger.sv
design/bank_table_top.sv
tests/tb_clock_gen.sv
tests/bank_table_tb.sv

// File: tests/bank_table_tb.sv
`timescale 1ns/1ps

// Directed testbench for the banked lookup table
module bank_table_tb;

  import bank_table_pkg::*;

  localparam int TABLE_SIZE = NUM_BANKS * BANK_DEPTH;

  // Four full-table read passes plus the clears, with slack for the short tests
  localparam int EST_CYCLES     = 4 * (TABLE_SIZE + BANK_DEPTH) + 180;
  localparam int TIMEOUT_CYCLES = 4 * EST_CYCLES;
  localparam int unsigned SEED  = 32'hfe79_ee6c;

  logic        clk;
  logic        arst_n;
  logic        init_start;
  word_t       init_value;
  logic        wr_en;
  logic        rd_en;
  table_addr_t addr;
  word_t       wr_data;
  word_t       rd_data;
  logic        rd_valid;
  logic        busy;
  logic        req_dropped;

  // Reference copy of the whole table, indexed by host address
  word_t ref_mem [TABLE_SIZE];
  word_t last_init;
  int    value_errors;
  int    protocol_errors;
  int    cycle_count;

  tb_clock_gen #(
    .PERIOD_NS    (20),
    .RESET_CYCLES (2)
  ) clk_gen0 (
    .clk    (clk),
    .arst_n (arst_n)
  );

  bank_table_top dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .init_start  (init_start),
    .init_value  (init_value),
    .wr_en       (wr_en),
    .rd_en       (rd_en),
    .addr        (addr),
    .wr_data     (wr_data),
    .rd_data     (rd_data),
    .rd_valid    (rd_valid),
    .busy        (busy),
    .req_dropped (req_dropped)
  );

  // ------------------------------------------------------------
  // Check helpers
  // ------------------------------------------------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      value_errors++;
      $display("FAIL at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic check_flag(input logic cond, input string what);
    assert (cond === 1'b1) else begin
      protocol_errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  // ------------------------------------------------------------
  // Bus actions, all entered and left just after a falling edge
  // ------------------------------------------------------------

  // Pulses init_start and updates the model; busy must be up one cycle later
  task automatic start_init(input word_t value);
    init_value = value;
    init_start = 1'b1;
    @(negedge clk);
    init_start = 1'b0;
    foreach (ref_mem[i]) ref_mem[i] = value;
    last_init = value;
    check_flag(busy, "busy did not rise after init_start");
  endtask

  // Counts busy cycles; a nonzero restart_at repeats the start pulse mid-clear
  task automatic count_busy_cycles(input int restart_at, output int cycles);
    cycles = 0;
    while (busy === 1'b1) begin
      cycles++;
      init_start = (cycles == restart_at);
      @(negedge clk);
    end
    init_start = 1'b0;
  endtask

  task automatic write_word(input table_addr_t a, input word_t d);
    wr_en   = 1'b1;
    addr    = a;
    wr_data = d;
    @(negedge clk);
    wr_en = 1'b0;
    ref_mem[a] = d;
    check_flag(!req_dropped, $sformatf("write to address %0d was dropped while idle", a));
  endtask

  // The result of a read is visible at the next falling edge
  task automatic read_expect(input table_addr_t a);
    rd_en = 1'b1;
    addr  = a;
    @(negedge clk);
    rd_en = 1'b0;
    check_flag(rd_valid, $sformatf("read of address %0d returned no rd_valid", a));
    check_value($sformatf("rd_data[%0d]", a), ref_mem[a], rd_data);
  endtask

  task automatic read_all();
    for (int a = 0; a < TABLE_SIZE; a++) begin
      read_expect(table_addr_t'(a));
    end
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------

  task automatic test_reset_state();
    check_flag(!busy, "busy is not low after reset");
    check_flag(!rd_valid, "rd_valid is not low after reset");
    check_flag(!req_dropped, "req_dropped is not low after reset");
  endtask

  task automatic test_init();
    int cycles;
    start_init(word_t'($urandom));
    count_busy_cycles(0, cycles);
    check_value("busy cycles", BANK_DEPTH, cycles);
    read_all();
  endtask

  // Back-to-back writes, then back-to-back reads of the same addresses
  task automatic test_write_read();
    table_addr_t addrs[$];
    table_addr_t a;
    repeat (32) begin
      a = table_addr_t'($urandom);
      addrs.push_back(a);
      write_word(a, word_t'($urandom));
    end
    foreach (addrs[i]) begin
      read_expect(addrs[i]);
    end
  endtask

  task automatic test_drop_during_init();
    table_addr_t a;
    int          cycles;
    start_init(word_t'($urandom));
    // Alternate writes and reads, all well inside the clear
    for (int k = 0; k < 6; k++) begin
      a       = table_addr_t'($urandom);
      wr_en   = (k % 2 == 0);
      rd_en   = (k % 2 != 0);
      addr    = a;
      wr_data = word_t'($urandom);
      @(negedge clk);
      wr_en = 1'b0;
      rd_en = 1'b0;
      check_flag(req_dropped, "request during initialization did not raise req_dropped");
      check_flag(!rd_valid, "read during initialization produced rd_valid");
    end
    count_busy_cycles(0, cycles);
    check_flag(!req_dropped, "req_dropped stayed high after initialization");
    // Dropped writes must have left the cleared value in place
    read_all();
  endtask

  task automatic test_reinit();
    word_t value;
    int    cycles;
    // Leave written words behind so the clear has something to overwrite
    repeat (8) write_word(table_addr_t'($urandom), word_t'($urandom));
    do begin
      value = word_t'($urandom);
    end while (value == last_init);
    start_init(value);
    // Second pulse halfway must not stretch busy
    count_busy_cycles(BANK_DEPTH / 2, cycles);
    check_value("busy cycles with restart", BANK_DEPTH, cycles);
    read_all();
  endtask

  // Read and write of one entry in one cycle returns the old word
  task automatic test_same_cycle();
    table_addr_t a;
    word_t       old_word;
    word_t       new_word;
    repeat (4) begin
      a        = table_addr_t'($urandom);
      old_word = ref_mem[a];
      do begin
        new_word = word_t'($urandom);
      end while (new_word == old_word);
      wr_en   = 1'b1;
      rd_en   = 1'b1;
      addr    = a;
      wr_data = new_word;
      @(negedge clk);
      wr_en = 1'b0;
      rd_en = 1'b0;
      check_flag(rd_valid, $sformatf("same-cycle read of address %0d gave no rd_valid", a));
      check_value($sformatf("rd_data[%0d] same cycle", a), old_word, rd_data);
      ref_mem[a] = new_word;
      read_expect(a);
    end
  endtask

  // ------------------------------------------------------------
  // Run control
  // ------------------------------------------------------------

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles before the tests finished", cycle_count);
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    int unsigned seed_ret;
    seed_ret   = $urandom(SEED);
    init_start = 1'b0;
    init_value = '0;
    wr_en      = 1'b0;
    rd_en      = 1'b0;
    addr       = '0;
    wr_data    = '0;
    wait (arst_n === 1'b1);
    @(negedge clk);

    test_reset_state();
    test_init();
    test_write_read();
    test_drop_during_init();
    test_reinit();
    test_same_cycle();

    $display("Value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
    if (value_errors + protocol_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

// Free-running clock and power-on reset for the testbench
module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset goes away on a falling edge, clear of the sampling edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// File: design/bank_table_top.sv
`timescale 1ns/1ps

`include "bank_table_defines.svh"

// Banked lookup table with interleaved addressing and parallel clear
module bank_table_top (
  input  logic                        clk,
  input  logic                        arst_n,
  // Clear control, fanned out to every bank
  input  logic                        init_start,
  input  bank_table_pkg::word_t       init_value,
  // Host access
  input  logic                        wr_en,
  input  logic                        rd_en,
  input  bank_table_pkg::table_addr_t addr,
  input  bank_table_pkg::word_t       wr_data,
  output bank_table_pkg::word_t       rd_data,
  output logic                        rd_valid,
  // Status
  output logic                        busy,
  output logic                        req_dropped
);

  import bank_table_pkg::*;

  // Router to banks
  bank_mask_t bank_wr_mask;
  bank_mask_t bank_rd_mask;
  index_t     index;
  word_t      bank_wr_data;

  // Router to merger
  bank_num_t  rd_bank;

  // Banks to merger
  word_t [`BANK_TABLE_NUM_BANKS-1:0] bank_rd_data;
  bank_mask_t                        bank_rd_valid;
  logic  [`BANK_TABLE_NUM_BANKS-1:0] bank_busy;

  // ---------------------------------------------------------
  // Request decode
  // ---------------------------------------------------------

  bank_router u_router (
    .clk          (clk),
    .arst_n       (arst_n),
    .wr_en        (wr_en),
    .rd_en        (rd_en),
    .addr         (addr),
    .wr_data      (wr_data),
    .busy         (busy),
    .bank_wr_mask (bank_wr_mask),
    .bank_rd_mask (bank_rd_mask),
    .index        (index),
    .bank_wr_data (bank_wr_data),
    .rd_bank      (rd_bank),
    .req_dropped  (req_dropped)
  );

  // ---------------------------------------------------------
  // Banks
  // ---------------------------------------------------------

  // Every bank sees the same index and data, only its mask bit differs
  for (genvar b = 0; b < `BANK_TABLE_NUM_BANKS; b++) begin : g_bank
    table_bank #(
      .DEPTH     (`BANK_TABLE_BANK_DEPTH),
      .payload_t (word_t)
    ) u_bank (
      .clk        (clk),
      .arst_n     (arst_n),
      .init_start (init_start),
      .init_value (init_value),
      .wr_sel     (bank_wr_mask[b]),
      .rd_sel     (bank_rd_mask[b]),
      .index      (index),
      .wr_data    (bank_wr_data),
      .rd_data    (bank_rd_data[b]),
      .rd_valid   (bank_rd_valid[b]),
      .busy       (bank_busy[b])
    );
  end

  // ---------------------------------------------------------
  // Read return and status
  // ---------------------------------------------------------

  read_merger u_merger (
    .clk           (clk),
    .arst_n        (arst_n),
    .rd_bank       (rd_bank),
    .bank_rd_data  (bank_rd_data),
    .bank_rd_valid (bank_rd_valid),
    .bank_busy     (bank_busy),
    .rd_data       (rd_data),
    .rd_valid      (rd_valid),
    .busy          (busy)
  );

endmodule

// File: design/read_merger.sv
`timescale 1ns/1ps

// Collects the per-bank read results into one read port and folds
// the per-bank clear levels into one busy level
module read_merger (
  input  logic                                                  clk,
  input  logic                                                  arst_n,
  // Bank number of the read issued this cycle
  input  bank_table_pkg::bank_num_t                             rd_bank,
  // Registered read words and valids of all banks
  input  bank_table_pkg::word_t [bank_table_pkg::NUM_BANKS-1:0] bank_rd_data,
  input  bank_table_pkg::bank_mask_t                            bank_rd_valid,
  // Clear levels of all banks
  input  logic [bank_table_pkg::NUM_BANKS-1:0]                  bank_busy,
  // Merged read port
  output bank_table_pkg::word_t                                 rd_data,
  output logic                                                  rd_valid,
  // High while any bank is clearing
  output logic                                                  busy
);

  import bank_table_pkg::*;

  // Bank number delayed to line up with the bank's read register
  bank_num_t rd_bank_q;

  // ---------------------------------------------------------
  // Read return path
  // ---------------------------------------------------------

  // Sampled on the same edge as the bank read, so it names the bank
  // whose rd_valid is up in the following cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_bank_q <= '0;
    end else begin
      rd_bank_q <= rd_bank;
    end
  end

  assign rd_data  = bank_rd_data[rd_bank_q];
  assign rd_valid = |bank_rd_valid;

  // All banks clear together, but any one of them still clearing
  // is enough to hold off the host
  assign busy = |bank_busy;

  // ---------------------------------------------------------
  // Checks
  // ---------------------------------------------------------

  // Only one read can be in flight per cycle
  one_read_valid_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0(bank_rd_valid)
  );

  // The delayed bank number must point at the bank that answered
  rd_bank_matches_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    rd_valid |-> bank_rd_valid[rd_bank_q]
  );

endmodule

// File: design/bank_router.sv
`timescale 1ns/1ps

// Splits a host address into bank number and index, turns the bank
// number into one-hot selects and drops requests during a clear
module bank_router (
  input  logic                        clk,
  input  logic                        arst_n,
  // Host request strobes
  input  logic                        wr_en,
  input  logic                        rd_en,
  input  bank_table_pkg::table_addr_t addr,
  input  bank_table_pkg::word_t       wr_data,
  // Combined clear level from all banks
  input  logic                        busy,
  // Per-bank selects that stay zero when idle or dropped
  output bank_table_pkg::bank_mask_t  bank_wr_mask,
  output bank_table_pkg::bank_mask_t  bank_rd_mask,
  // Shared to all banks
  output bank_table_pkg::index_t      index,
  output bank_table_pkg::word_t       bank_wr_data,
  // Bank number of the current read, picked up by the merger
  output bank_table_pkg::bank_num_t   rd_bank,
  // One-cycle flag for a request that arrived while busy
  output logic                        req_dropped
);

  import bank_table_pkg::*;

  bank_num_t  bank_num;
  bank_mask_t bank_onehot;
  logic       wr_ok;
  logic       rd_ok;

  // ---------------------------------------------------------
  // Address decode
  // ---------------------------------------------------------

  // Low bits pick the bank and the rest is the entry within it
  assign {index, bank_num} = addr;

  assign bank_onehot = bank_mask_t'(1) << bank_num;

  // Requests are only accepted while no bank is clearing
  assign wr_ok = wr_en && !busy;
  assign rd_ok = rd_en && !busy;

  assign bank_wr_mask = wr_ok ? bank_onehot : '0;
  assign bank_rd_mask = rd_ok ? bank_onehot : '0;

  // Write data is common to all banks and the mask decides who takes it
  assign bank_wr_data = wr_data;
  assign rd_bank      = bank_num;

  // Drop flag raised one cycle after the rejected request
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_dropped <= 1'b0;
    end else begin
      req_dropped <= busy && (wr_en || rd_en);
    end
  end

  // At most one bank may see a given request
  mask_onehot_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    $onehot0(bank_wr_mask) && $onehot0(bank_rd_mask)
  );

endmodule

// File: design/table_bank.sv
`timescale 1ns/1ps

`include "bank_table_defines.svh"

// One bank of the table: a storage array with one write port and one
// synchronous read port, plus its own clear sequencer
module table_bank #(
  // Entries in this bank, matches the index width of the package
  parameter int  DEPTH     = `BANK_TABLE_BANK_DEPTH,
  // Payload held in each entry
  parameter type payload_t = bank_table_pkg::word_t
) (
  input  logic                    clk,
  input  logic                    arst_n,
  // Clear request and the value every entry is cleared to
  input  logic                    init_start,
  input  payload_t                init_value,
  // Host strobes, already gated off by the router during a clear
  input  logic                    wr_sel,
  input  logic                    rd_sel,
  input  bank_table_pkg::index_t  index,
  input  payload_t                wr_data,
  // Read result, valid for one cycle after rd_sel
  output payload_t                rd_data,
  output logic                    rd_valid,
  // High while this bank is clearing
  output logic                    busy
);

  import bank_table_pkg::*;

  // Storage array
  payload_t mem [DEPTH];

  // Write port of the clear sequencer
  logic     init_wr_valid;
  index_t   init_wr_addr;
  payload_t init_wr_data;

  // Merged write port into the array
  logic     mem_we;
  index_t   mem_addr;
  payload_t mem_wdata;

  // ---------------------------------------------------------
  // Clear sequencer
  // ---------------------------------------------------------

  ram_initializer #(
    .DEPTH     (DEPTH),
    .payload_t (payload_t)
  ) u_init (
    .clk           (clk),
    .arst_n        (arst_n),
    .initial_value (init_value),
    .start         (init_start),
    .busy          (busy),
    .wr_valid      (init_wr_valid),
    .wr_addr       (init_wr_addr),
    .wr_data       (init_wr_data)
  );

  // ---------------------------------------------------------
  // Write port arbitration
  // ---------------------------------------------------------

  // The sequencer owns the port for the whole clear
  // Outside a clear the host write goes straight through
  always_comb begin
    if (init_wr_valid) begin
      mem_we    = 1'b1;
      mem_addr  = init_wr_addr;
      mem_wdata = init_wr_data;
    end else begin
      mem_we    = wr_sel;
      mem_addr  = index;
      mem_wdata = wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  // ---------------------------------------------------------
  // Read port
  // ---------------------------------------------------------

  // The read samples the array before a same-edge write lands,
  // so a read and write to one entry in one cycle returns the old word
  always_ff @(posedge clk) begin
    if (rd_sel) begin
      rd_data <= mem[index];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_sel;
    end
  end

  // The router is expected to block host traffic for the whole clear;
  // a host select here would corrupt the array or read stale data
  no_host_during_init_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    init_wr_valid |-> !(wr_sel || rd_sel)
  );

endmodule

// File: design/ram_initializer.sv
`timescale 1ns/1ps

// Walks every entry of a RAM once after a start pulse and writes the
// same value into each one
module ram_initializer #(
  // Number of entries to write, at least 2
  parameter int  DEPTH     = 2,
  // Payload stored in each entry
  parameter type payload_t = logic
) (
  input  logic                     clk,
  input  logic                     arst_n,
  // Value written into every entry, held stable by the user while busy
  input  payload_t                 initial_value,
  // First write happens on the cycle after start is sampled
  // A start pulse during busy has no effect
  input  logic                     start,
  output logic                     busy,
  // Write port toward the RAM
  output logic                     wr_valid,
  output logic [$clog2(DEPTH)-1:0] wr_addr,
  output payload_t                 wr_data
);

  localparam int ADDR_WIDTH = $clog2(DEPTH);

  // Address of the final entry, where the walk ends
  localparam logic [ADDR_WIDTH-1:0] ADDR_LAST = ADDR_WIDTH'(DEPTH - 1);

  typedef enum logic {
    st_idle = 1'b0,
    st_busy = 1'b1
  } state_t;

  state_t                  state;
  state_t                  state_next;
  logic [ADDR_WIDTH-1:0]   addr_next;

  // ---------------------------------------------------------
  // Sequencer
  // ---------------------------------------------------------

  // Every busy cycle issues exactly one write
  assign busy     = (state == st_busy);
  assign wr_valid = (state == st_busy);
  assign wr_data  = initial_value;

  always_comb begin
    state_next = state;
    addr_next  = wr_addr;
    case (state)
      st_idle: begin
        if (start) begin
          state_next = st_busy;
        end
      end
      st_busy: begin
        // Wrap to zero so the next run starts from entry 0 again
        if (wr_addr == ADDR_LAST) begin
          state_next = st_idle;
          addr_next  = '0;
        end else begin
          addr_next = wr_addr + 1'b1;
        end
      end
      default: begin
        state_next = st_idle;
        addr_next  = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= st_idle;
      wr_addr <= '0;
    end else begin
      state   <= state_next;
      wr_addr <= addr_next;
    end
  end

  // ---------------------------------------------------------
  // Checks
  // ---------------------------------------------------------

  // The counter must never run past the array, also across the wrap
  wr_addr_in_range_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    wr_valid |-> (wr_addr < DEPTH)
  );

  // A value change mid-run would leave the RAM with mixed contents
  initial_value_stable_a : assert property (
    @(posedge clk) disable iff (!arst_n)
    busy |-> $stable(initial_value)
  );

endmodule

// File: design/bank_table_pkg.sv
`include "bank_table_defines.svh"

package bank_table_pkg;

  // Geometry taken over from the defines header
  localparam int NUM_BANKS  = `BANK_TABLE_NUM_BANKS;
  localparam int BANK_DEPTH = `BANK_TABLE_BANK_DEPTH;
  localparam int WORD_WIDTH = `BANK_TABLE_WORD_WIDTH;

  // Field widths of a host address
  localparam int BANK_BITS  = $clog2(NUM_BANKS);
  localparam int INDEX_BITS = $clog2(BANK_DEPTH);

  // One stored word
  typedef logic [WORD_WIDTH-1:0] word_t;

  // Entry index within one bank
  typedef logic [INDEX_BITS-1:0] index_t;

  // Bank number, taken from the low address bits
  typedef logic [BANK_BITS-1:0] bank_num_t;

  // Host address, index in the upper bits and bank number in the lower bits
  // so that consecutive addresses land in consecutive banks
  typedef logic [INDEX_BITS+BANK_BITS-1:0] table_addr_t;

  // One bit per bank, used for one-hot selects
  typedef logic [NUM_BANKS-1:0] bank_mask_t;

endpackage

// File: design/bank_table_defines.svh
`ifndef BANK_TABLE_DEFINES_SVH
`define BANK_TABLE_DEFINES_SVH

// ---------------------------------------------------------
// Table geometry
// ---------------------------------------------------------

// Number of banks, must be a power of two and at least 2
`define BANK_TABLE_NUM_BANKS 4

// Entries per bank, at least 2
// A full clear takes this many cycles because all banks clear together
`define BANK_TABLE_BANK_DEPTH 16

// Bits per stored word
`define BANK_TABLE_WORD_WIDTH 16

`endif
